// File: design/packet_pkg.sv
////////////////////////////////////////
// packet definitions
// opcode encoding and prefix layout shared by the
// command decoder and the output encoder
////////////////////////////////////////

package packet_pkg;

    // four packet kinds, so the prefix holds exactly two bits
    localparam int NUM_OPC = 4;
    localparam int PFX_WIDTH = $clog2(NUM_OPC);

    // prefix sits in the top bits of a packet, payload fills the rest
    typedef logic [PFX_WIDTH-1:0] opcode_t;

    // on the command side RUN and FIN step the network n times,
    // on the output side they report n elapsed steps
    localparam opcode_t RUN = 2'd0;
    localparam opcode_t FIN = 2'd1;

    // payload is an input index on the command side and an
    // output index on the output side
    localparam opcode_t SPK = 2'd2;

    // clear carries no payload
    localparam opcode_t CLR = 2'd3;

endpackage

// File: design/network_pkg.sv
////////////////////////////////////////
// network definitions
// neuron potential type and the fixed input
// connectivity of the output neurons
////////////////////////////////////////

package network_pkg;

    localparam int POT_WIDTH = 8;
    typedef logic [POT_WIDTH-1:0] potential_t;

    // upper bound on the input count that a mask can describe
    localparam int MAX_INP = 32;
    typedef logic [MAX_INP-1:0] inp_mask_t;

    // output neuron j listens to inputs j and j+1, wrapping at num_inp,
    // each with weight 1
    // with a single input both taps land on the same bit, so the
    // neuron then sees that input once
    function automatic inp_mask_t input_mask(int j, int num_inp);
        inp_mask_t mask;
        mask = '0;
        mask[j % num_inp] = 1'b1;
        mask[(j + 1) % num_inp] = 1'b1;
        return mask;
    endfunction

endpackage

// File: design/network_source.sv
////////////////////////////////////////
// network source
// decodes command packets into network steps,
// input spikes and clear pulses
////////////////////////////////////////

module network_source #(
    parameter int PKT_WIDTH = 8,
    parameter int NUM_INP = 4
) (
    input  logic                 clk,
    input  logic                 arstn,
    input  logic                 src_valid,
    input  logic [PKT_WIDTH-1:0] src,
    output logic                 src_ready,
    output logic                 net_valid,
    output logic                 net_last,
    input  logic                 net_ready,
    output logic [NUM_INP-1:0]   inp_spikes,
    output logic                 net_arstn
);
    import packet_pkg::*;

    localparam int RUN_WIDTH = PKT_WIDTH - PFX_WIDTH;

    typedef enum logic [1:0] {idle, stepping, clearing} state_t;
    state_t state;

    opcode_t opcode;
    logic [RUN_WIDTH-1:0] payload;
    logic [RUN_WIDTH-1:0] steps_left;
    logic [NUM_INP-1:0] pending;
    logic fin_cmd;
    logic accept;
    logic step;

    assign opcode = src[PKT_WIDTH-1 -: PFX_WIDTH];
    assign payload = src[RUN_WIDTH-1:0];

    // commands are only taken while no steps or clear are in flight
    assign src_ready = (state == idle);
    assign accept = src_valid && src_ready;

    assign net_valid = (state == stepping);
    assign net_last = net_valid && fin_cmd && (steps_left == RUN_WIDTH'(1));
    assign inp_spikes = net_valid ? pending : '0;
    assign step = net_valid && net_ready;

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            state <= idle;
            steps_left <= '0;
            fin_cmd <= 1'b0;
            net_arstn <= 1'b1;
        end else begin
            net_arstn <= 1'b1;
            case (state)
                idle: begin
                    if (accept) begin
                        if ((opcode == RUN || opcode == FIN) && payload != '0) begin
                            steps_left <= payload;
                            fin_cmd <= (opcode == FIN);
                            state <= stepping;
                        end else if (opcode == CLR) begin
                            // one cycle low pulse, lined up with the clearing state
                            net_arstn <= 1'b0;
                            state <= clearing;
                        end
                    end
                end
                stepping: begin
                    if (step) begin
                        steps_left <= steps_left - 1'b1;
                        if (steps_left == RUN_WIDTH'(1)) begin
                            state <= idle;
                        end
                    end
                end
                clearing: state <= idle;
                default: state <= idle;
            endcase
        end
    end

    // pending inputs go out with the first step of the next run and are
    // dropped after it; a clear throws them away as well
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            pending <= '0;
        end else if (accept && opcode == SPK) begin
            for (int i = 0; i < NUM_INP; i++) begin
                if (payload == RUN_WIDTH'(i)) begin
                    pending[i] <= 1'b1;
                end
            end
        end else if (step || (accept && opcode == CLR)) begin
            pending <= '0;
        end
    end

    // the sink may stall a step, and the core must see the same inputs until it is taken
    assert property (@(posedge clk) disable iff (!arstn)
        net_valid && !net_ready |=> net_valid && $stable(inp_spikes) && $stable(net_last))
        else $error("step link changed while stalled");

endmodule

// File: design/spiking_core.sv
////////////////////////////////////////
// spiking core
// integrate-and-fire neurons with fixed two-input
// connectivity, firing on the presented step
////////////////////////////////////////

module spiking_core #(
    parameter int NUM_INP = 4,
    parameter int NUM_OUT = 4,
    parameter network_pkg::potential_t THRESHOLD = 3
) (
    input  logic               clk,
    input  logic               arstn,
    input  logic               net_arstn,
    input  logic               net_valid,
    input  logic               net_ready,
    input  logic [NUM_INP-1:0] inp_spikes,
    output logic [NUM_OUT-1:0] net_out
);
    import network_pkg::*;

    potential_t pot [NUM_OUT];

    // one extra bit so the sum cannot wrap before the compare
    logic [POT_WIDTH:0] sum [NUM_OUT];

    logic core_rstn;
    logic step;

    // a clear command wipes the potentials just like a global reset
    assign core_rstn = arstn && net_arstn;
    assign step = net_valid && net_ready;

    // firing is combinational so the sink sees the outcome of the step on offer
    always_comb begin
        inp_mask_t mask;
        for (int j = 0; j < NUM_OUT; j++) begin
            mask = input_mask(j, NUM_INP);
            sum[j] = {1'b0, pot[j]};
            for (int i = 0; i < NUM_INP; i++) begin
                if (mask[i] && inp_spikes[i]) begin
                    sum[j] = sum[j] + 1'b1;
                end
            end
            net_out[j] = (sum[j] >= THRESHOLD);
        end
    end

    always_ff @(posedge clk or negedge core_rstn) begin
        if (!core_rstn) begin
            for (int j = 0; j < NUM_OUT; j++) begin
                pot[j] <= '0;
            end
        end else if (step) begin
            for (int j = 0; j < NUM_OUT; j++) begin
                // a fired neuron starts over from zero
                pot[j] <= net_out[j] ? '0 : sum[j][POT_WIDTH-1:0];
            end
        end
    end

    for (genvar j = 0; j < NUM_OUT; j++) begin : g_check
        // anything that reaches the threshold must have fired and been reset
        assert property (@(posedge clk) disable iff (!core_rstn)
            step |=> pot[j] < THRESHOLD)
            else $error("neuron %0d kept a potential at or above threshold", j);
    end

endmodule

// File: design/network_sink.sv
////////////////////////////////////////
// network sink
// encodes accepted network steps into RUN, FIN,
// SPK and CLR output packets
////////////////////////////////////////

module network_sink #(
    parameter int PKT_WIDTH = 8,
    parameter int NUM_OUT = 4
) (
    input  logic                 clk,
    input  logic                 arstn,
    input  logic                 net_valid,
    input  logic                 net_last,
    output logic                 net_ready,
    input  logic                 net_arstn,
    input  logic [NUM_OUT-1:0]   net_out,
    input  logic                 snk_ready,
    output logic                 snk_valid,
    output logic [PKT_WIDTH-1:0] snk
);
    import packet_pkg::*;

    localparam int RUN_WIDTH = PKT_WIDTH - PFX_WIDTH;

    typedef enum logic [1:0] {idle, runs, spikes, clear} state_t;
    state_t state;

    // steps taken since the last RUN or FIN packet
    logic [RUN_WIDTH-1:0] run_cnt;
    logic [RUN_WIDTH-1:0] run_len;
    logic [NUM_OUT-1:0] fires;
    logic last;
    logic clr_pend;
    logic step;
    logic trigger;
    logic flush;
    logic load_run;
    logic [RUN_WIDTH-1:0] fire_idx;
    logic [NUM_OUT-1:0] fire_bit;

    // a pending clear is handled before any new step is taken
    assign net_ready = (state == idle) && !clr_pend;
    assign step = net_valid && net_ready;
    assign trigger = (run_cnt != '0) && (|net_out || net_last || &run_cnt);

    // clear with steps still uncounted reports them first, then the counter restarts at 0
    assign flush = (state == idle) && clr_pend && (run_cnt != '0);
    assign load_run = flush || (step && trigger);

    // lowest fired output not yet reported
    always_comb begin
        fire_idx = '0;
        fire_bit = '0;
        for (int i = NUM_OUT - 1; i >= 0; i--) begin
            if (fires[i]) begin
                fire_idx = RUN_WIDTH'(i);
                fire_bit = '0;
                fire_bit[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arstn or negedge net_arstn) begin
        if (!arstn) begin
            clr_pend <= 1'b0;
        end else if (!net_arstn) begin
            clr_pend <= 1'b1;
        end else if (state == clear && snk_ready) begin
            clr_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load_run) begin
            run_len <= run_cnt;
            last <= step && net_last;
        end
    end

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            state <= idle;
            run_cnt <= '0;
            fires <= '0;
        end else begin
            case (state)
                idle: begin
                    if (flush) begin
                        run_cnt <= '0;
                        state <= runs;
                    end else if (clr_pend) begin
                        state <= clear;
                    end else if (step) begin
                        fires <= net_out;
                        if (trigger) begin
                            // the triggering step opens the next run
                            run_cnt <= RUN_WIDTH'(1);
                            state <= runs;
                        end else begin
                            run_cnt <= run_cnt + 1'b1;
                            if (|net_out) begin
                                state <= spikes;
                            end
                        end
                    end
                end
                runs: begin
                    if (snk_ready) begin
                        state <= (|fires) ? spikes : idle;
                    end
                end
                spikes: begin
                    if (snk_ready) begin
                        fires <= fires & ~fire_bit;
                        if ((fires & ~fire_bit) == '0) begin
                            state <= idle;
                        end
                    end
                end
                clear: begin
                    if (snk_ready) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_comb begin
        snk_valid = 1'b0;
        snk = '0;
        case (state)
            runs: begin
                snk_valid = 1'b1;
                snk = {(last ? FIN : RUN), run_len};
            end
            spikes: begin
                snk_valid = 1'b1;
                snk = {SPK, fire_idx};
            end
            clear: begin
                snk_valid = 1'b1;
                snk = {CLR, {RUN_WIDTH{1'b0}}};
            end
            default: ;
        endcase
    end

    assert property (@(posedge clk) disable iff (!arstn)
        snk_valid && !snk_ready |=> snk_valid && $stable(snk))
        else $error("output packet changed while stalled");

endmodule

// File: design/snn_top.sv
////////////////////////////////////////
// spiking network slice
// command decoder, neuron core and packet encoder
////////////////////////////////////////

module snn_top #(
    parameter int PKT_WIDTH = 8,
    parameter int NUM_INP = 4,
    parameter int NUM_OUT = 4,
    parameter network_pkg::potential_t THRESHOLD = 3
) (
    input  logic                 clk,
    input  logic                 arstn,
    input  logic                 src_valid,
    input  logic [PKT_WIDTH-1:0] src,
    output logic                 src_ready,
    input  logic                 snk_ready,
    output logic                 snk_valid,
    output logic [PKT_WIDTH-1:0] snk
);
    // step link, shared by all three blocks
    logic net_valid;
    logic net_last;
    logic net_ready;
    logic net_arstn;
    logic [NUM_INP-1:0] inp_spikes;
    logic [NUM_OUT-1:0] net_out;

    network_source #(
        .PKT_WIDTH(PKT_WIDTH),
        .NUM_INP(NUM_INP)
    ) network_source_i (
        .clk(clk),
        .arstn(arstn),
        .src_valid(src_valid),
        .src(src),
        .src_ready(src_ready),
        .net_valid(net_valid),
        .net_last(net_last),
        .net_ready(net_ready),
        .inp_spikes(inp_spikes),
        .net_arstn(net_arstn)
    );

    spiking_core #(
        .NUM_INP(NUM_INP),
        .NUM_OUT(NUM_OUT),
        .THRESHOLD(THRESHOLD)
    ) spiking_core_i (
        .clk(clk),
        .arstn(arstn),
        .net_arstn(net_arstn),
        .net_valid(net_valid),
        .net_ready(net_ready),
        .inp_spikes(inp_spikes),
        .net_out(net_out)
    );

    network_sink #(
        .PKT_WIDTH(PKT_WIDTH),
        .NUM_OUT(NUM_OUT)
    ) network_sink_i (
        .clk(clk),
        .arstn(arstn),
        .net_valid(net_valid),
        .net_last(net_last),
        .net_ready(net_ready),
        .net_arstn(net_arstn),
        .net_out(net_out),
        .snk_ready(snk_ready),
        .snk_valid(snk_valid),
        .snk(snk)
    );

endmodule

// File: test/snn_model.svh
////////////////////////////////////////
// network reference model
// predicts the output packets of each accepted
// command and queues them for comparison
////////////////////////////////////////

`ifndef SNN_MODEL_SVH
`define SNN_MODEL_SVH

logic [PKT_WIDTH-1:0] expected [$];
logic [NUM_INP-1:0] model_pending;
potential_t model_pot [NUM_OUT];
int model_run_cnt;

function automatic logic [PKT_WIDTH-1:0] make_packet(opcode_t op, int payload);
    return {op, RUN_WIDTH'(payload)};
endfunction

function automatic void restart_model();
    model_pending = '0;
    model_run_cnt = 0;
    for (int j = 0; j < NUM_OUT; j++) begin
        model_pot[j] = '0;
    end
endfunction

// one network step followed by the packets the output encoder owes for it
function automatic void advance_network(logic [NUM_INP-1:0] inp, bit last);
    logic [NUM_OUT-1:0] fired;
    int tap_a;
    int tap_b;
    int sum;
    fired = '0;
    for (int j = 0; j < NUM_OUT; j++) begin
        tap_a = j % NUM_INP;
        tap_b = (j + 1) % NUM_INP;
        sum = int'(model_pot[j]) + int'(inp[tap_a]);
        // with a single input both taps are the same wire
        if (tap_b != tap_a) begin
            sum = sum + int'(inp[tap_b]);
        end
        fired[j] = (sum >= THRESHOLD);
        model_pot[j] = fired[j] ? potential_t'(0) : potential_t'(sum);
    end
    if (model_run_cnt != 0 && (fired != '0 || last || model_run_cnt == MAX_RUN)) begin
        expected.push_back(make_packet(last ? FIN : RUN, model_run_cnt));
        model_run_cnt = 1;
    end else begin
        model_run_cnt = model_run_cnt + 1;
    end
    for (int j = 0; j < NUM_OUT; j++) begin
        if (fired[j]) begin
            expected.push_back(make_packet(SPK, j));
        end
    end
endfunction

function automatic void predict_command(logic [PKT_WIDTH-1:0] cmd);
    opcode_t op;
    int payload;
    op = cmd[PKT_WIDTH-1 -: PFX_WIDTH];
    payload = int'(cmd[RUN_WIDTH-1:0]);
    if (op == SPK) begin
        if (payload < NUM_INP) begin
            model_pending[payload] = 1'b1;
        end
    end else if (op == CLR) begin
        if (model_run_cnt != 0) begin
            expected.push_back(make_packet(RUN, model_run_cnt));
        end
        restart_model();
        expected.push_back(make_packet(CLR, 0));
    end else if (payload != 0) begin
        // inputs only ride along on the first step of a run
        for (int s = 0; s < payload; s++) begin
            advance_network((s == 0) ? model_pending : '0, op == FIN && s == payload - 1);
        end
        model_pending = '0;
    end
endfunction

`endif

// File: test/snn_tb.sv
////////////////////////////////////////
// spiking network testbench
// directed and random commands, every output
// packet compared with the reference model
////////////////////////////////////////

module snn_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import packet_pkg::*;
    import network_pkg::*;

    localparam int PKT_WIDTH = 8;
    localparam int NUM_INP = 4;
    localparam int NUM_OUT = 4;
    localparam potential_t THRESHOLD = 3;
    localparam int RUN_WIDTH = PKT_WIDTH - PFX_WIDTH;
    localparam int MAX_RUN = (1 << RUN_WIDTH) - 1;
    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_DIRECTED = 13;
    localparam int NUM_RANDOM = 400;
    localparam int NUM_CMDS = NUM_DIRECTED + NUM_RANDOM;
    // each command may be a longest run whose steps all emit a full, stalled burst
    localparam longint WATCHDOG_CYCLES =
        longint'(NUM_CMDS) * (1 + MAX_RUN) * (NUM_OUT + 2) * 4;

    logic clk;
    logic arstn;
    logic src_valid;
    logic [PKT_WIDTH-1:0] src;
    logic src_ready;
    logic snk_ready;
    logic snk_valid;
    logic [PKT_WIDTH-1:0] snk;
    logic [15:0] lfsr;
    logic src_taken;
    int received;
    bit stepped_since_clear;

    `include "snn_model.svh"

    snn_top #(
        .PKT_WIDTH(PKT_WIDTH),
        .NUM_INP(NUM_INP),
        .NUM_OUT(NUM_OUT),
        .THRESHOLD(THRESHOLD)
    ) snn_top_i (
        .clk(clk),
        .arstn(arstn),
        .src_valid(src_valid),
        .src(src),
        .src_ready(src_ready),
        .snk_ready(snk_ready),
        .snk_valid(snk_valid),
        .snk(snk)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // taps of x^16 + x^14 + x^13 + x^11 + 1 with the new bit entering at the bottom
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int take_bits(int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
        return value;
    endfunction

    task automatic stop_run(string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(string name, logic [PKT_WIDTH-1:0] expected_value,
                         logic [PKT_WIDTH-1:0] actual);
        if (actual !== expected_value) begin
            $display("FAILED %s: expected %h, actual %h", name, expected_value, actual);
            stop_run("a checked value did not match");
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        // the output side stalls about one cycle in four
        snk_ready = (take_bits(2) != 0);
    endtask

    task automatic send_command(logic [PKT_WIDTH-1:0] cmd);
        int gap;
        gap = take_bits(2);
        repeat (gap) begin
            next_cycle();
        end
        predict_command(cmd);
        if (cmd[PKT_WIDTH-1 -: PFX_WIDTH] == CLR) begin
            stepped_since_clear = 1'b0;
        end else if (cmd[PKT_WIDTH-1 -: PFX_WIDTH] != SPK && cmd[RUN_WIDTH-1:0] != '0) begin
            stepped_since_clear = 1'b1;
        end
        src = cmd;
        src_valid = 1'b1;
        next_cycle();
        while (!src_taken) begin
            next_cycle();
        end
        src_valid = 1'b0;
    endtask

    function automatic logic [PKT_WIDTH-1:0] random_command();
        int kind;
        logic [PKT_WIDTH-1:0] cmd;
        kind = take_bits(4);
        if (kind < 7) begin
            cmd = make_packet(SPK, take_bits(RUN_WIDTH) % NUM_INP);
        end else if (kind < 12) begin
            cmd = make_packet(RUN, take_bits(2));
        end else if (kind < 14) begin
            cmd = make_packet(FIN, take_bits(2));
        end else if (kind == 14 && stepped_since_clear) begin
            // two clears with no step between them would share one clear latch in the sink
            cmd = make_packet(CLR, 0);
        end else begin
            cmd = make_packet(RUN, MAX_RUN - take_bits(2));
        end
        return cmd;
    endfunction

    always @(posedge clk) begin
        src_taken <= src_valid && src_ready;
        if (arstn && snk_valid && snk_ready) begin
            received = received + 1;
            if (expected.size() == 0) begin
                stop_run($sformatf("output packet %h arrived with none expected", snk));
            end else begin
                check($sformatf("packet %0d", received), expected.pop_front(), snk);
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) begin
            @(posedge clk);
        end
        stop_run("timeout: the design stopped accepting commands or sending packets");
    end

    initial begin
        lfsr = 16'd78;
        arstn = 1'b0;
        src_valid = 1'b0;
        src = '0;
        snk_ready = 1'b0;
        src_taken = 1'b0;
        received = 0;
        stepped_since_clear = 1'b1;
        restart_model();
        repeat (RESET_CYCLES) begin
            @(negedge clk);
        end
        arstn = 1'b1;
        repeat (4) begin
            next_cycle();
            check("idle src_ready", 1'b1, src_ready);
            check("idle snk_valid", 1'b0, snk_valid);
        end
        // neuron 0 fires on the second step, neurons 1 and 3 keep what they gathered
        send_command(make_packet(SPK, 0));
        send_command(make_packet(SPK, 1));
        send_command(make_packet(RUN, 1));
        send_command(make_packet(SPK, 0));
        send_command(make_packet(SPK, 1));
        send_command(make_packet(RUN, 1));
        send_command(make_packet(SPK, 2));
        send_command(make_packet(FIN, 3));
        // long idle run forces a full count
        send_command(make_packet(RUN, MAX_RUN));
        send_command(make_packet(CLR, 0));
        // neuron 3 held 2 before the clear, so input 3 alone must not fire it now
        send_command(make_packet(SPK, 3));
        send_command(make_packet(RUN, 2));
        send_command(make_packet(FIN, 1));
        repeat (NUM_RANDOM) begin
            send_command(random_command());
        end
        while (expected.size() != 0) begin
            next_cycle();
        end
        // a quiet tail lets any extra packet show up in the monitor
        repeat (4 * (NUM_OUT + 2)) begin
            next_cycle();
        end
        $display("All checks passed");
        $finish;
    end

endmodule

// File: sources.f
+incdir+test
design/packet_pkg.sv
design/network_pkg.sv
design/network_source.sv
design/spiking_core.sv
design/network_sink.sv
design/snn_top.sv
test/snn_tb.sv

// File: Makefile
# Verilator build and run of the spiking network testbench

VERILATOR ?= verilator
TOP       ?= snn_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal
FAIL_MSG  ?= Checks failed
PASS_MSG  ?= All checks passed

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
